// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

	// Datapath widths
	localparam int XLEN = 32;
	localparam int TAG_WIDTH = 8;

	typedef logic [XLEN-1:0] addr_t;
	typedef logic [XLEN-1:0] word_t;
	typedef logic [TAG_WIDTH-1:0] fetch_tag_t;

	// Cache geometry
	localparam int NUM_WAYS = 2;
	localparam int NUM_SETS = 8;
	localparam int WORDS_PER_LINE = 4;

	// Tag in bits 31 to 7, set in 6 to 4 and word in 3 to 2
	localparam int WORD_LSB = 2;
	localparam int SET_LSB = 4;
	localparam int TAG_LSB = 7;

	typedef logic [2:0] set_index_t;
	typedef logic [1:0] line_word_t;
	typedef logic [XLEN-TAG_LSB-1:0] cache_tag_t;
	typedef logic way_index_t;

	localparam addr_t RESET_PC = 32'h0000_0000;

	// Major opcodes seen by the predecoder
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// Full encodings of the privileged instructions
	localparam word_t INSTR_MRET = 32'h3020_0073;
	localparam word_t INSTR_WFI = 32'h1050_0073;

	typedef enum logic {
		FETCH_RUN,
		FETCH_WAIT_REDIRECT
	} fetch_state_e;

	typedef enum logic [1:0] {
		CACHE_LOOKUP,
		CACHE_FILL,
		CACHE_REFILL_DONE
	} cache_state_e;

endpackage

// ==== hdl/icache_way.sv ====
`timescale 1ns/1ps

module icache_way import fetch_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	// Lookup
	input set_index_t i_set,
	input cache_tag_t i_tag,
	input line_word_t i_word,
	output logic o_hit,
	output word_t o_data,

	// Line fill
	input logic i_fill_write,
	input line_word_t i_fill_word,
	input word_t i_fill_data,
	input logic i_fill_last
);

	cache_tag_t tag_mem [NUM_SETS];
	word_t data_mem [NUM_SETS][WORDS_PER_LINE];
	logic [NUM_SETS-1:0] valid;

	// Stored tag must match and the line must be complete
	assign o_hit = valid[i_set] && (tag_mem[i_set] == i_tag);
	assign o_data = data_mem[i_set][i_word];

	// Line turns valid with its last fill word
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			valid <= '0;
		end
		else if (i_fill_write && i_fill_last) begin
			valid[i_set] <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_fill_write) begin
			data_mem[i_set][i_fill_word] <= i_fill_data;
			// Tag goes in with the last word of the line
			if (i_fill_last) begin
				tag_mem[i_set] <= i_tag;
			end
		end
	end

endmodule

// ==== hdl/icache.sv ====
`timescale 1ns/1ps

module icache import fetch_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	// Fetch side
	input logic i_lookup,
	input addr_t i_address,
	output logic o_hit,
	output word_t o_data,

	// Bus
	output logic o_bus_valid,
	input logic i_bus_ready,
	output addr_t o_bus_address,
	input word_t i_bus_rdata
);

	cache_state_e state;

	set_index_t set;
	cache_tag_t tag;
	line_word_t word;

	logic [NUM_WAYS-1:0] way_hit;
	word_t way_data [NUM_WAYS];
	logic any_hit;

	// Miss handling
	way_index_t victim;
	way_index_t rr_ptr [NUM_SETS];
	line_word_t fill_word;
	logic bus_fire;
	logic fill_last;

	assign set = i_address[SET_LSB +: $bits(set_index_t)];
	assign tag = i_address[TAG_LSB +: $bits(cache_tag_t)];
	assign word = i_address[WORD_LSB +: $bits(line_word_t)];

	assign bus_fire = o_bus_valid && i_bus_ready;
	assign fill_last = (fill_word == line_word_t'(WORDS_PER_LINE - 1));

	genvar w;
	generate
		for (w = 0; w < NUM_WAYS; w++) begin : g_way
			icache_way way_i (
				.i_clock(i_clock),
				.i_reset(i_reset),
				.i_set(set),
				.i_tag(tag),
				.i_word(word),
				.o_hit(way_hit[w]),
				.o_data(way_data[w]),
				// Only the victim way takes the fill
				.i_fill_write(bus_fire && (victim == way_index_t'(w))),
				.i_fill_word(fill_word),
				.i_fill_data(i_bus_rdata),
				.i_fill_last(fill_last)
			);
		end
	endgenerate

	assign any_hit = |way_hit;

	// Hit is reported only once the controller is back in lookup
	assign o_hit = any_hit && (state == CACHE_LOOKUP);

	always_comb begin
		o_data = '0;
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (way_hit[i]) begin
				o_data = way_data[i];
			end
		end
	end

	// Line reads walk word 0 to 3 from the aligned address
	assign o_bus_valid = (state == CACHE_FILL);
	assign o_bus_address = {i_address[XLEN-1:SET_LSB], fill_word, 2'b00};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= CACHE_LOOKUP;
			victim <= '0;
			fill_word <= '0;
			for (int s = 0; s < NUM_SETS; s++) begin
				rr_ptr[s] <= '0;
			end
		end
		else begin
			case (state)
				CACHE_LOOKUP: begin
					if (i_lookup && !any_hit) begin
						victim <= rr_ptr[set];
						fill_word <= '0;
						state <= CACHE_FILL;
					end
				end

				CACHE_FILL: begin
					if (bus_fire) begin
						fill_word <= fill_word + 1'b1;
						if (fill_last) begin
							// Next miss in this set evicts the other way
							if (rr_ptr[set] == way_index_t'(NUM_WAYS - 1)) begin
								rr_ptr[set] <= '0;
							end
							else begin
								rr_ptr[set] <= rr_ptr[set] + 1'b1;
							end
							state <= CACHE_REFILL_DONE;
						end
					end
				end

				CACHE_REFILL_DONE: begin
					state <= CACHE_LOOKUP;
				end

				default: begin
					state <= CACHE_LOOKUP;
				end
			endcase
		end
	end

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	// Cache
	output logic o_lookup,
	output addr_t o_address,
	input logic i_hit,
	input word_t i_data,

	// Back end control
	input logic i_redirect,
	input addr_t i_redirect_pc,

	// Decode
	output logic o_valid,
	input logic i_ready,
	output fetch_tag_t o_tag,
	output word_t o_instruction,
	output addr_t o_pc
);

	fetch_state_e state;
	fetch_state_e next_state;

	addr_t pc;
	addr_t next_pc;

	logic room;
	logic load;

	// Predecode
	logic [6:0] opcode;
	logic is_jump;
	logic is_branch;
	logic is_mret;
	logic is_wfi;
	logic is_control;

	assign opcode = i_data[6:0];
	assign is_jump = (opcode == OPC_JAL) || (opcode == OPC_JALR);
	assign is_branch = (opcode == OPC_BRANCH);
	assign is_mret = (opcode == OPC_SYSTEM) && (i_data == INSTR_MRET);
	assign is_wfi = (opcode == OPC_SYSTEM) && (i_data == INSTR_WFI);
	assign is_control = is_jump || is_branch || is_mret || is_wfi;

	// Output register is free when empty or draining this cycle
	assign room = !o_valid || i_ready;

	assign o_lookup = (state == FETCH_RUN);
	assign o_address = pc;

	always_comb begin
		next_state = state;
		next_pc = pc;
		load = 1'b0;

		case (state)
			FETCH_RUN: begin
				if (i_hit && room) begin
					load = 1'b1;
					if (is_control) begin
						// Target unknown here so the back end redirects
						next_state = FETCH_WAIT_REDIRECT;
					end
					else begin
						next_pc = pc + 32'd4;
					end
				end
			end

			FETCH_WAIT_REDIRECT: begin
				if (i_redirect) begin
					next_pc = i_redirect_pc;
					next_state = FETCH_RUN;
				end
			end

			default: begin
				next_state = FETCH_RUN;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= FETCH_RUN;
			pc <= RESET_PC;
			o_valid <= 1'b0;
			o_tag <= '0;
		end
		else begin
			state <= next_state;
			pc <= next_pc;
			if (load) begin
				o_valid <= 1'b1;
				o_tag <= o_tag + 1'b1;
			end
			else if (i_ready) begin
				o_valid <= 1'b0;
			end
		end
	end

	// Instruction and its address
	always_ff @(posedge i_clock) begin
		if (load) begin
			o_instruction <= i_data;
			o_pc <= pc;
		end
	end

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	// Redirect from the back end
	input logic i_redirect,
	input addr_t i_redirect_pc,

	// Decode
	output logic o_valid,
	input logic i_ready,
	output fetch_tag_t o_tag,
	output word_t o_instruction,
	output addr_t o_pc,

	// Instruction bus
	output logic o_bus_valid,
	input logic i_bus_ready,
	output addr_t o_bus_address,
	input word_t i_bus_rdata
);

	logic lookup;
	addr_t lookup_address;
	logic hit;
	word_t hit_data;

	fetch_unit fetch_unit_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.o_lookup(lookup),
		.o_address(lookup_address),
		.i_hit(hit),
		.i_data(hit_data),
		.i_redirect(i_redirect),
		.i_redirect_pc(i_redirect_pc),
		.o_valid(o_valid),
		.i_ready(i_ready),
		.o_tag(o_tag),
		.o_instruction(o_instruction),
		.o_pc(o_pc)
	);

	icache icache_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_lookup(lookup),
		.i_address(lookup_address),
		.o_hit(hit),
		.o_data(hit_data),
		.o_bus_valid(o_bus_valid),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata)
	);

endmodule

// ==== verification/mem_pattern.svh ====
// Addresses of the three control-transfer words
localparam logic [31:0] JAL_ADDRESS = 32'h0000_0038;
localparam logic [31:0] BRANCH_ADDRESS = 32'h0000_00d8;
localparam logic [31:0] WFI_ADDRESS = 32'h0000_015c;

// ADDI x1 with address bits 11 to 2 as immediate and the upper bits folded into rs1
function automatic logic [31:0] word_at(input logic [31:0] address);
	logic [4:0] source;
	logic [31:0] word;
	source = address[16:12] ^ address[21:17] ^ address[26:22] ^ address[31:27];
	case (address)
		JAL_ADDRESS: word = 32'h0000_006f;
		BRANCH_ADDRESS: word = 32'h0000_0063;
		WFI_ADDRESS: word = 32'h1050_0073;
		default: word = {2'b00, address[11:2], source, 3'b000, 5'd1, 7'b0010011};
	endcase
	return word;
endfunction

// The three addresses where fetch must stop
function automatic logic is_control_address(input logic [31:0] address);
	return (address == JAL_ADDRESS) || (address == BRANCH_ADDRESS) ||
		(address == WFI_ADDRESS);
endfunction

// ==== verification/instr_mem_model.sv ====
`timescale 1ns/1ps

module instr_mem_model import fetch_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	output logic o_ready,
	input addr_t i_address,
	output word_t o_rdata
);

	`include "mem_pattern.svh"

	logic pending;
	logic [1:0] delay;

	// Ready and data change on the falling edge only
	initial begin
		o_ready = 1'b0;
		o_rdata = '0;
		pending = 1'b0;
		delay = '0;
		forever begin
			@(negedge i_clock);
			if (i_reset || o_ready) begin
				// Ready during the last cycle means the word was taken
				o_ready = 1'b0;
				pending = 1'b0;
			end
			else if (i_valid && !pending) begin
				pending = 1'b1;
				delay = 2'($urandom_range(3, 0));
			end
			else if (pending && (delay != 2'd0)) begin
				delay = delay - 2'd1;
			end
			else if (pending) begin
				o_ready = 1'b1;
				o_rdata = word_at(i_address);
			end
		end
	end

endmodule

// ==== verification/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

	`include "mem_pattern.svh"

	localparam int WAIT_LIMIT = 1000;

	logic i_clock = 1'b0;
	logic i_reset;
	logic redirect;
	addr_t redirect_pc;
	logic valid;
	logic ready;
	fetch_tag_t tag;
	word_t instruction;
	addr_t pc;
	logic bus_valid;
	logic bus_ready;
	addr_t bus_address;
	word_t bus_rdata;

	// Scoreboard state updated at the rising edge
	addr_t expect_pc;
	fetch_tag_t expect_tag;
	logic waiting_redirect;
	int transfer_count;
	int bus_count;
	addr_t bus_log [$];
	logic held;
	fetch_tag_t held_tag;
	word_t held_instruction;
	addr_t held_pc;

	fetch_top fetch_top_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_redirect(redirect),
		.i_redirect_pc(redirect_pc),
		.o_valid(valid),
		.i_ready(ready),
		.o_tag(tag),
		.o_instruction(instruction),
		.o_pc(pc),
		.o_bus_valid(bus_valid),
		.i_bus_ready(bus_ready),
		.o_bus_address(bus_address),
		.i_bus_rdata(bus_rdata)
	);

	instr_mem_model mem_model_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(bus_valid),
		.o_ready(bus_ready),
		.i_address(bus_address),
		.o_rdata(bus_rdata)
	);

	initial begin
		forever #2 i_clock = ~i_clock;
	end

	// Decode back-pressure with ready three cycles in four on average
	initial begin
		ready = 1'b0;
		forever begin
			@(negedge i_clock);
			ready = ($urandom_range(3, 0) != 0);
		end
	end

	task automatic report_mismatch(input string what);
		$display("Mismatch at time %0t: %s", $time, what);
		$display("Simulation failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
		$display("Simulation failed");
		$fatal(1, "stopping at first error");
	endtask

	always @(posedge i_clock) begin
		if (i_reset) begin
			expect_pc = RESET_PC;
			expect_tag = 8'd1;
			waiting_redirect = 1'b0;
			transfer_count = 0;
			bus_count = 0;
			held = 1'b0;
		end
		else begin
			if (held) begin
				assert (valid && (tag == held_tag) && (instruction == held_instruction) &&
					(pc == held_pc)) else report_mismatch("decode outputs moved while stalled");
			end
			held = valid && !ready;
			held_tag = tag;
			held_instruction = instruction;
			held_pc = pc;
			// Redirect counts only while fetch is parked
			if (redirect && waiting_redirect) begin
				expect_pc = redirect_pc;
				waiting_redirect = 1'b0;
			end
			if (valid && ready) begin
				assert (!waiting_redirect) else report_mismatch("transfer before redirect");
				assert (pc == expect_pc)
					else report_mismatch($sformatf("pc %h, expected %h", pc, expect_pc));
				assert (instruction == word_at(pc)) else report_mismatch(
					$sformatf("instruction %h at %h, expected %h", instruction, pc,
					word_at(pc)));
				assert (tag == expect_tag)
					else report_mismatch($sformatf("tag %0d, expected %0d", tag, expect_tag));
				expect_pc = pc + 32'd4;
				expect_tag = expect_tag + 8'd1;
				waiting_redirect = is_control_address(pc);
				transfer_count++;
			end
			// Line fills are four reads from the aligned address upward
			if (bus_valid && bus_ready) begin
				if ((bus_count % 4) == 0) begin
					assert (bus_address[3:0] == 4'h0)
						else report_mismatch($sformatf("unaligned fill start %h", bus_address));
				end
				else begin
					assert (bus_address == bus_log[bus_count - 1] + 32'd4)
						else report_mismatch(
						$sformatf("fill address %h out of order", bus_address));
				end
				bus_log.push_back(bus_address);
				bus_count++;
			end
		end
	end

	task automatic wait_for_transfers(input int target, input string what);
		int cycles = 0;
		while (transfer_count < target) begin
			@(negedge i_clock);
			cycles++;
			if (cycles > WAIT_LIMIT) report_timeout(what);
		end
	endtask

	task automatic wait_for_stop(input string what);
		int cycles = 0;
		while (!waiting_redirect) begin
			@(negedge i_clock);
			cycles++;
			if (cycles > WAIT_LIMIT) report_timeout(what);
		end
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge i_clock);
			assert (!valid) else report_mismatch("o_valid high without a redirect");
		end
	endtask

	task automatic send_redirect(input addr_t target);
		redirect = 1'b1;
		redirect_pc = target;
		@(negedge i_clock);
		redirect = 1'b0;
	endtask

	task automatic run_from(input addr_t target);
		send_redirect(target);
		wait_for_stop($sformatf("stop after redirect to %h", target));
	endtask

	initial begin
		int bus_before;
		int seen;
		void'($urandom(32'h6d4c));
		i_reset = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		repeat (4) @(posedge i_clock);
		@(negedge i_clock);
		assert (!valid && !bus_valid) else report_mismatch("valid outputs high after reset");
		i_reset = 1'b0;

		// A pulse while running must not disturb the sequence
		wait_for_transfers(3, "third transfer after reset");
		send_redirect(32'h0000_0700);
		wait_for_stop("JAL after reset");
		check_idle(40);

		// Lines 0x00 to 0x30 are resident now
		bus_before = bus_count;
		run_from(32'h0000_0008);
		assert (bus_count == bus_before) else report_mismatch("bus traffic on cached lines");

		// Enough transfers to wrap the tag
		repeat (16) run_from(RESET_PC);

		// Set 5 takes A (0x050), B (0x0d0) and then C (0x150), which evicts A
		run_from(32'h0000_0050);
		run_from(32'h0000_0150);
		bus_before = bus_count;
		run_from(32'h0000_00d0);
		assert (bus_count == bus_before) else report_mismatch("line B was evicted");
		bus_before = bus_count;
		seen = transfer_count;
		send_redirect(32'h0000_0050);
		wait_for_transfers(seen + 1, "first transfer of line A");
		assert ((bus_count == bus_before + 4) && (bus_log[bus_before] == 32'h0000_0050))
			else report_mismatch("line A was not refilled");
		wait_for_stop("branch after line A");

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+verification
hdl/fetch_pkg.sv
hdl/icache_way.sv
hdl/icache.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
verification/instr_mem_model.sv
verification/fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the fetch testbench with Verilator.
# The exit status is nonzero when the testbench stops with $fatal.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_tb -f flist.f -o fetch_sim \
	&& ./obj_dir/fetch_sim \
	|| { echo "fetch_tb run did not pass"; exit 1; }
